/* rtl/axil_pkg.sv */
package axil_pkg;

  localparam int ADDR_W = 4;
  localparam int DATA_W = 32;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } resp_t;

  // Register offsets
  localparam logic [ADDR_W-1:0] REG_CMD    = 4'h0;
  localparam logic [ADDR_W-1:0] REG_STATUS = 4'h4;
  localparam logic [ADDR_W-1:0] REG_RXDATA = 4'h8;

  // Status register bits
  localparam int STAT_BUSY    = 0;
  localparam int STAT_RXVALID = 1;

endpackage

/* rtl/axil_spi_regs.sv */
module axil_spi_regs (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [axil_pkg::ADDR_W-1:0]   awaddr,
  input  logic                          awvalid,
  output logic                          awready,
  input  logic [axil_pkg::DATA_W-1:0]   wdata,
  input  logic [axil_pkg::DATA_W/8-1:0] wstrb,
  input  logic                          wvalid,
  output logic                          wready,
  output axil_pkg::resp_t               bresp,
  output logic                          bvalid,
  input  logic                          bready,
  input  logic [axil_pkg::ADDR_W-1:0]   araddr,
  input  logic                          arvalid,
  output logic                          arready,
  output logic [axil_pkg::DATA_W-1:0]   rdata,
  output axil_pkg::resp_t               rresp,
  output logic                          rvalid,
  input  logic                          rready,
  spi_req_if.host                       req
);

  logic                        wr_accept;
  logic                        rd_accept;
  logic                        cmd_write;
  logic                        rx_valid;
  spi_frame_pkg::spi_cmd_u     last_cmd;
  spi_frame_pkg::spi_cmd_u     cmd_next;
  spi_frame_pkg::rd_data_t     rx_byte;
  logic [axil_pkg::DATA_W-1:0] status_word;
  logic [axil_pkg::DATA_W-1:0] rd_word;
  axil_pkg::resp_t             rd_resp;

  // Address and data are taken together, one response at a time
  assign wr_accept = awvalid && wvalid && !bvalid;
  assign rd_accept = arvalid && !rvalid;
  assign awready   = wr_accept;
  assign wready    = wr_accept;
  assign arready   = rd_accept;
  assign cmd_write = wr_accept && (awaddr == axil_pkg::REG_CMD);

  // Byte lanes not strobed keep the previous command
  always_comb
  begin
    cmd_next = last_cmd;
    if (wstrb[0])
      cmd_next.raw[7:0] = wdata[7:0];
    if (wstrb[1])
      cmd_next.raw[spi_frame_pkg::CMD_BITS-1:8] = wdata[spi_frame_pkg::CMD_BITS-1:8];
  end

  assign req.req_valid = cmd_write && req.req_ready;
  assign req.cmd       = cmd_next;

  always_comb
  begin
    status_word = '0;
    status_word[axil_pkg::STAT_BUSY]    = !req.req_ready;
    status_word[axil_pkg::STAT_RXVALID] = rx_valid;
  end

  always_comb
  begin
    rd_word = '0;
    rd_resp = axil_pkg::OKAY;
    case (araddr)
      axil_pkg::REG_CMD:    rd_word[spi_frame_pkg::CMD_BITS-1:0] = last_cmd.raw;
      axil_pkg::REG_STATUS: rd_word = status_word;
      axil_pkg::REG_RXDATA: rd_word[spi_frame_pkg::RD_BITS-1:0] = rx_byte;
      default:              rd_resp = axil_pkg::SLVERR;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bvalid   <= 1'b0;
      rvalid   <= 1'b0;
      rx_valid <= 1'b0;
      last_cmd <= '0;
    end
    else
    begin
      if (wr_accept)
        bvalid <= 1'b1;
      else if (bready)
        bvalid <= 1'b0;
      if (rd_accept)
        rvalid <= 1'b1;
      else if (rready)
        rvalid <= 1'b0;
      if (req.rx_strobe)
        rx_valid <= 1'b1;  // New byte wins over a clearing read
      else if (rd_accept && araddr == axil_pkg::REG_RXDATA)
        rx_valid <= 1'b0;
      if (req.req_valid)
        last_cmd <= cmd_next;
    end
  end

  // Response payload, held stable while the valid is up
  always_ff @(posedge clk)
  begin
    if (wr_accept)
    begin
      if (req.req_valid)
        bresp <= axil_pkg::OKAY;
      else
        bresp <= axil_pkg::SLVERR;  // Busy, read-only or unmapped
    end
    if (rd_accept)
    begin
      rdata <= rd_word;
      rresp <= rd_resp;
    end
    if (req.rx_strobe)
      rx_byte <= req.rx_data;
  end

endmodule

/* rtl/spi_frame_pkg.sv */
package spi_frame_pkg;

  localparam int CMD_BITS = 12;
  localparam int HDR_BITS = 4;
  localparam int RD_BITS  = 8;

  // Field view of the command word
  typedef struct packed {
    logic       is_write;  // Frame type select
    logic [2:0] reg_addr;
    logic [7:0] wr_data;
  } spi_cmd_fields_t;

  typedef union packed {
    logic [CMD_BITS-1:0] raw;  // As shifted out on MOSI
    spi_cmd_fields_t     f;
  } spi_cmd_u;

  typedef logic [RD_BITS-1:0] rd_data_t;

  // Bits in one chip select window
  typedef logic [3:0] burst_len_t;

endpackage

/* rtl/spi_frame_seq.sv */
module spi_frame_seq #(
  parameter int READ_GAP = 16
) (
  input  logic       clk,
  input  logic       rst_n,
  spi_req_if.engine  req,
  spi_shift_if.seq   sh
);

  localparam int GAP_W = $clog2(READ_GAP + 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_WRITE,
    S_HEADER,
    S_GAP,
    S_READ
  } state_t;

  state_t                  state;
  logic [GAP_W-1:0]        gap_cnt;
  logic                    accept;
  logic                    gap_end;
  spi_frame_pkg::spi_cmd_u cmd;

  assign cmd     = req.cmd;
  assign accept  = req.req_valid && req.req_ready;
  assign gap_end = (state == S_GAP) && (gap_cnt == GAP_W'(READ_GAP - 1));

  // Read result goes up with the same edge that frees the engine
  assign req.rx_strobe = (state == S_READ) && sh.done;
  assign req.rx_data   = sh.rx_bits;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state         <= S_IDLE;
      req.req_ready <= 1'b1;
      sh.start      <= 1'b0;
      gap_cnt       <= '0;
    end
    else
    begin
      sh.start <= 1'b0;
      case (state)
        S_IDLE:
          if (accept)
          begin
            req.req_ready <= 1'b0;
            sh.start      <= 1'b1;
            state         <= cmd.f.is_write ? S_WRITE : S_HEADER;
          end
        S_WRITE, S_READ:
          if (sh.done)
          begin
            req.req_ready <= 1'b1;
            state         <= S_IDLE;
          end
        S_HEADER:
          if (sh.done)
          begin
            gap_cnt <= '0;
            state   <= S_GAP;
          end
        S_GAP:
          if (gap_end)
          begin
            sh.start <= 1'b1;
            state    <= S_READ;
          end
          else
            gap_cnt <= gap_cnt + 1'b1;
        default:
          state <= S_IDLE;
      endcase
    end
  end

  // Burst setup, loaded the cycle before each start
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      if (cmd.f.is_write)
      begin
        sh.nbits   <= spi_frame_pkg::burst_len_t'(spi_frame_pkg::CMD_BITS);
        sh.tx_bits <= cmd.raw;
      end
      else
      begin
        sh.nbits   <= spi_frame_pkg::burst_len_t'(spi_frame_pkg::HDR_BITS);
        sh.tx_bits <= {cmd.f.is_write, cmd.f.reg_addr, 8'h00};  // Header only
      end
    end
    else if (gap_end)
    begin
      sh.nbits   <= spi_frame_pkg::burst_len_t'(spi_frame_pkg::RD_BITS);
      sh.tx_bits <= '0;  // MOSI quiet while reading
    end
  end

endmodule

/* rtl/spi_master_top.sv */
module spi_master_top #(
  parameter int CLK_DIV  = 4,
  parameter int READ_GAP = 16
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [axil_pkg::ADDR_W-1:0]   awaddr,
  input  logic                          awvalid,
  output logic                          awready,
  input  logic [axil_pkg::DATA_W-1:0]   wdata,
  input  logic [axil_pkg::DATA_W/8-1:0] wstrb,
  input  logic                          wvalid,
  output logic                          wready,
  output axil_pkg::resp_t               bresp,
  output logic                          bvalid,
  input  logic                          bready,
  input  logic [axil_pkg::ADDR_W-1:0]   araddr,
  input  logic                          arvalid,
  output logic                          arready,
  output logic [axil_pkg::DATA_W-1:0]   rdata,
  output axil_pkg::resp_t               rresp,
  output logic                          rvalid,
  input  logic                          rready,
  output logic                          sclk,
  output logic                          cs_n,
  output logic                          mosi,
  input  logic                          miso
);

  spi_req_if   req_bus ();
  spi_shift_if shift_bus ();

  axil_spi_regs u_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .req     (req_bus.host)
  );

  spi_frame_seq #(
    .READ_GAP (READ_GAP)
  ) u_seq (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req_bus.engine),
    .sh    (shift_bus.seq)
  );

  spi_shifter #(
    .CLK_DIV (CLK_DIV)
  ) u_shifter (
    .clk   (clk),
    .rst_n (rst_n),
    .sh    (shift_bus.shifter),
    .sclk  (sclk),
    .cs_n  (cs_n),
    .mosi  (mosi),
    .miso  (miso)
  );

endmodule

/* rtl/spi_req_if.sv */
interface spi_req_if;

  logic                    req_valid;
  spi_frame_pkg::spi_cmd_u cmd;
  logic                    req_ready;  // Low while a frame runs
  logic                    rx_strobe;
  spi_frame_pkg::rd_data_t rx_data;

  modport host (
    output req_valid,
    output cmd,
    input  req_ready,
    input  rx_strobe,
    input  rx_data
  );

  modport engine (
    input  req_valid,
    input  cmd,
    output req_ready,
    output rx_strobe,
    output rx_data
  );

endinterface

/* rtl/spi_shift_if.sv */
interface spi_shift_if;

  logic                                start;
  spi_frame_pkg::burst_len_t           nbits;
  logic [spi_frame_pkg::CMD_BITS-1:0]  tx_bits;  // Left aligned
  logic                                done;
  spi_frame_pkg::rd_data_t             rx_bits;

  modport seq (
    output start,
    output nbits,
    output tx_bits,
    input  done,
    input  rx_bits
  );

  modport shifter (
    input  start,
    input  nbits,
    input  tx_bits,
    output done,
    output rx_bits
  );

endinterface

/* rtl/spi_shifter.sv */
module spi_shifter #(
  parameter int CLK_DIV = 4
) (
  input  logic         clk,
  input  logic         rst_n,
  spi_shift_if.shifter sh,
  output logic         sclk,
  output logic         cs_n,
  output logic         mosi,
  input  logic         miso
);

  localparam int DIV_W = $clog2(CLK_DIV + 1);
  localparam int TX_W  = spi_frame_pkg::CMD_BITS;
  localparam int RX_W  = spi_frame_pkg::RD_BITS;

  typedef enum logic [1:0] {
    SH_IDLE,
    SH_RUN,
    SH_TAIL
  } sh_state_t;

  sh_state_t                 state;
  logic [DIV_W-1:0]          div_cnt;
  spi_frame_pkg::burst_len_t bits_left;
  logic [TX_W-1:0]           tx_sh;
  logic [RX_W-1:0]           rx_sh;
  logic                      phase_end;
  logic                      rise;
  logic                      fall;

  assign phase_end  = (state == SH_RUN) && (div_cnt == DIV_W'(CLK_DIV - 1));
  assign rise       = phase_end && !sclk;
  assign fall       = phase_end && sclk;
  assign sh.rx_bits = rx_sh;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= SH_IDLE;
      cs_n      <= 1'b1;
      sclk      <= 1'b0;
      mosi      <= 1'b0;
      sh.done   <= 1'b0;
      div_cnt   <= '0;
      bits_left <= '0;
    end
    else
    begin
      sh.done <= 1'b0;
      case (state)
        SH_IDLE:
          if (sh.start)
          begin
            state     <= SH_RUN;
            cs_n      <= 1'b0;
            div_cnt   <= '0;
            bits_left <= sh.nbits;
            mosi      <= sh.tx_bits[TX_W-1];  // First bit set up under SCLK low
          end
        SH_RUN:
          if (phase_end)
          begin
            div_cnt <= '0;
            sclk    <= !sclk;
            if (fall)
            begin
              if (bits_left == spi_frame_pkg::burst_len_t'(1))
                state <= SH_TAIL;
              else
              begin
                bits_left <= bits_left - 1'b1;
                mosi      <= tx_sh[TX_W-2];
              end
            end
          end
          else
            div_cnt <= div_cnt + 1'b1;
        SH_TAIL:
        begin
          cs_n    <= 1'b1;  // One cycle after the last falling edge
          mosi    <= 1'b0;
          sh.done <= 1'b1;
          state   <= SH_IDLE;
        end
        default:
          state <= SH_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == SH_IDLE && sh.start)
      tx_sh <= sh.tx_bits;
    else if (fall)
      tx_sh <= tx_sh << 1;
    if (rise)
      rx_sh <= {rx_sh[RX_W-2:0], miso};  // MSB first
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
  --top-module tb_spi_master \
  -f verilog.f

./obj_dir/Vtb_spi_master 2>&1 | tee sim.log

if grep -q "sim failed" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi

if ! grep -q "sim passed" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

/* testbench/spi_device_model.sv */
module spi_device_model (
  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  output logic miso
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [7:0]  regs [0:7];
  logic [11:0] shreg;
  logic [7:0]  tx_byte;
  logic [2:0]  rd_sel;
  logic        rd_pending;
  logic        in_window;
  int          bit_cnt;
  int          win_count;
  time         last_rise;

  // One entry per chip select window, word left aligned
  logic [11:0] win_word [0:63];
  int          win_bits [0:63];
  time         win_gap  [0:63];

  initial
  begin
    for (int i = 0; i < 8; i++)
      regs[i] = 8'h5a ^ {i[2:0], 2'b01, i[2:0]};  // Every address bit shows up
    miso       = 1'b0;
    shreg      = '0;
    tx_byte    = '0;
    rd_sel     = '0;
    rd_pending = 1'b0;
    in_window  = 1'b0;
    bit_cnt    = 0;
    win_count  = 0;
    last_rise  = 0;
  end

  always @(negedge cs_n)
  begin
    in_window = 1'b1;
    bit_cnt   = 0;
    shreg     = '0;
    win_gap[win_count % 64] = $time - last_rise;
    tx_byte = rd_pending ? regs[rd_sel] : 8'h00;
    miso    = tx_byte[7];  // First bit ready before the first rising edge
  end

  always @(posedge sclk)
  begin
    if (!cs_n)
    begin
      shreg   = {shreg[10:0], mosi};
      bit_cnt = bit_cnt + 1;
    end
  end

  always @(negedge sclk)
  begin
    if (!cs_n)
    begin
      tx_byte = {tx_byte[6:0], 1'b0};
      miso    = tx_byte[7];
    end
  end

  always @(posedge cs_n)
  begin
    if (in_window)
    begin
      in_window = 1'b0;
      last_rise = $time;
      win_bits[win_count % 64] = bit_cnt;
      win_word[win_count % 64] = shreg << (12 - bit_cnt);
      if (bit_cnt == 12 && shreg[11])
        regs[shreg[10:8]] = shreg[7:0];
      else if (bit_cnt == 4 && !shreg[3])
      begin
        rd_pending = 1'b1;  // Next window shifts this register out
        rd_sel     = shreg[2:0];
      end
      else if (bit_cnt == 8)
        rd_pending = 1'b0;
      win_count = win_count + 1;
      miso      = 1'b0;
    end
  end

endmodule

/* testbench/tb_spi_master.sv */
module tb_spi_master;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int  CLK_DIV     = 4;
  localparam int  READ_GAP    = 16;
  localparam int  CLK_PERIOD  = 20;
  localparam int  FRAME_CLKS  = 24 * 2 * CLK_DIV + READ_GAP;
  localparam time WATCHDOG_NS = 2 * 20 * FRAME_CLKS * CLK_PERIOD;

  logic                          clk;
  logic                          rst_n;
  logic [axil_pkg::ADDR_W-1:0]   awaddr;
  logic                          awvalid;
  logic                          awready;
  logic [axil_pkg::DATA_W-1:0]   wdata;
  logic [axil_pkg::DATA_W/8-1:0] wstrb;
  logic                          wvalid;
  logic                          wready;
  axil_pkg::resp_t               bresp;
  logic                          bvalid;
  logic                          bready;
  logic [axil_pkg::ADDR_W-1:0]   araddr;
  logic                          arvalid;
  logic                          arready;
  logic [axil_pkg::DATA_W-1:0]   rdata;
  axil_pkg::resp_t               rresp;
  logic                          rvalid;
  logic                          rready;
  logic                          sclk;
  logic                          cs_n;
  logic                          mosi;
  logic                          miso;
  logic [31:0]                   lfsr_state;
  spi_frame_pkg::spi_cmd_u       last_sent;  // Last command the DUT accepted

  spi_master_top #(
    .CLK_DIV  (CLK_DIV),
    .READ_GAP (READ_GAP)
  ) UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .sclk    (sclk),
    .cs_n    (cs_n),
    .mosi    (mosi),
    .miso    (miso)
  );

  spi_device_model u_model (
    .sclk (sclk),
    .cs_n (cs_n),
    .mosi (mosi),
    .miso (miso)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("sim failed");
    $fatal(1);
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    stop_on_error("Simulation timed out before all tests finished");
  end

  task automatic check_resp(input string name, input axil_pkg::resp_t got,
                            input axil_pkg::resp_t exp);
    if (got !== exp)
      stop_on_error($sformatf("FAIL %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_word(input string name, input logic [axil_pkg::DATA_W-1:0] got,
                            input logic [axil_pkg::DATA_W-1:0] exp);
    if (got !== exp)
      stop_on_error($sformatf("FAIL %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_byte(input string name, input spi_frame_pkg::rd_data_t got,
                            input spi_frame_pkg::rd_data_t exp);
    if (got !== exp)
      stop_on_error($sformatf("FAIL %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_frame(input string name, input spi_frame_pkg::spi_cmd_u got,
                             input int got_bits, input spi_frame_pkg::spi_cmd_u exp,
                             input int exp_bits);
    if (got.raw !== exp.raw || got_bits != exp_bits)
      stop_on_error($sformatf("FAIL %s: got %h (%h bits) expected %h (%h bits)",
                              name, got.raw, got_bits, exp.raw, exp_bits));
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      v          = {v[30:0], lfsr_state[0]};
    end
  endtask

  task automatic axi_write(input logic [axil_pkg::ADDR_W-1:0] addr,
                           input logic [axil_pkg::DATA_W-1:0] data,
                           output axil_pkg::resp_t resp);
    @(posedge clk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= '1;
    wvalid  <= 1'b1;
    @(negedge clk);
    while (!awready)
      @(negedge clk);
    check_word("wready", 32'(wready), 32'h1);
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(negedge clk);
    while (!bvalid)
      @(negedge clk);
    resp = bresp;
  endtask

  task automatic axi_read(input logic [axil_pkg::ADDR_W-1:0] addr,
                          output logic [axil_pkg::DATA_W-1:0] data,
                          output axil_pkg::resp_t resp);
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    @(negedge clk);
    while (!arready)
      @(negedge clk);
    @(posedge clk);
    arvalid <= 1'b0;
    @(negedge clk);
    while (!rvalid)
      @(negedge clk);
    data = rdata;
    resp = rresp;
  endtask

  task automatic read_status(output logic [axil_pkg::DATA_W-1:0] word);
    axil_pkg::resp_t r;
    axi_read(axil_pkg::REG_STATUS, word, r);
    check_resp("rresp status", r, axil_pkg::OKAY);
  endtask

  task automatic wait_idle(output logic [axil_pkg::DATA_W-1:0] word);
    do
      read_status(word);
    while (word[axil_pkg::STAT_BUSY]);
  endtask

  task automatic send_cmd(input spi_frame_pkg::spi_cmd_u cmd, input axil_pkg::resp_t exp);
    axil_pkg::resp_t r;
    axi_write(axil_pkg::REG_CMD, 32'(cmd.raw), r);
    check_resp("bresp cmd", r, exp);
    if (exp == axil_pkg::OKAY)
      last_sent = cmd;
  endtask

  task automatic write_frame(input logic [2:0] addr, input spi_frame_pkg::rd_data_t data);
    spi_frame_pkg::spi_cmd_u cmd;
    spi_frame_pkg::spi_cmd_u seen;
    logic [31:0]             st;
    int                      n0;
    cmd.f.is_write = 1'b1;
    cmd.f.reg_addr = addr;
    cmd.f.wr_data  = data;
    n0 = u_model.win_count;
    send_cmd(cmd, axil_pkg::OKAY);
    wait_idle(st);
    check_word("model window count", u_model.win_count, n0 + 1);
    seen.raw = u_model.win_word[n0 % 64];
    check_frame("write frame", seen, u_model.win_bits[n0 % 64], cmd, spi_frame_pkg::CMD_BITS);
    check_byte("model reg", u_model.regs[addr], data);
  endtask

  task automatic read_frame(input logic [2:0] addr, input spi_frame_pkg::rd_data_t exp);
    spi_frame_pkg::spi_cmd_u cmd;
    spi_frame_pkg::spi_cmd_u hdr;
    spi_frame_pkg::spi_cmd_u quiet;
    spi_frame_pkg::spi_cmd_u seen;
    logic [31:0]             st;
    logic [31:0]             w;
    axil_pkg::resp_t         r;
    int                      n0;
    cmd.f.is_write = 1'b0;
    cmd.f.reg_addr = addr;
    cmd.f.wr_data  = 8'h00;
    hdr.raw   = {cmd.raw[11:8], 8'h00};
    quiet.raw = '0;  // MOSI held low during the data burst
    n0 = u_model.win_count;
    send_cmd(cmd, axil_pkg::OKAY);
    wait_idle(st);
    check_word("status after read", st, 32'(1) << axil_pkg::STAT_RXVALID);
    check_word("model window count", u_model.win_count, n0 + 2);
    seen.raw = u_model.win_word[n0 % 64];
    check_frame("read header", seen, u_model.win_bits[n0 % 64], hdr, spi_frame_pkg::HDR_BITS);
    seen.raw = u_model.win_word[(n0 + 1) % 64];
    check_frame("read burst", seen, u_model.win_bits[(n0 + 1) % 64], quiet,
                spi_frame_pkg::RD_BITS);
    if (u_model.win_gap[(n0 + 1) % 64] < READ_GAP * CLK_PERIOD)
      stop_on_error("Chip select gap before the read burst was too short");
    axi_read(axil_pkg::REG_RXDATA, w, r);
    check_resp("rresp rxdata", r, axil_pkg::OKAY);
    check_byte("rxdata", w[7:0], exp);
    check_word("rdata rxdata", w, 32'(exp));
    read_status(st);
    check_word("status after rxdata", st, 32'h0);
  endtask

  task automatic test_reset();
    logic [31:0]     w;
    axil_pkg::resp_t r;
    @(negedge clk);
    check_word("cs_n", 32'(cs_n), 32'h1);
    check_word("sclk", 32'(sclk), 32'h0);
    check_word("mosi", 32'(mosi), 32'h0);
    axi_read(axil_pkg::REG_STATUS, w, r);
    check_resp("rresp status", r, axil_pkg::OKAY);
    check_word("status", w, 32'h0);
  endtask

  task automatic test_errors();
    spi_frame_pkg::spi_cmd_u  cmd_a;
    spi_frame_pkg::spi_cmd_u  cmd_b;
    spi_frame_pkg::rd_data_t  old_b;
    logic [31:0]              w;
    axil_pkg::resp_t          r;
    int                       n0;
    cmd_a.raw = {1'b1, 3'd1, 8'h3c};
    cmd_b.raw = {1'b1, 3'd2, 8'h99};
    old_b = u_model.regs[2];
    n0 = u_model.win_count;
    send_cmd(cmd_a, axil_pkg::OKAY);
    send_cmd(cmd_b, axil_pkg::SLVERR);  // Engine still busy with cmd_a
    wait_idle(w);
    check_word("model window count", u_model.win_count, n0 + 1);
    check_byte("model reg 1", u_model.regs[1], 8'h3c);
    check_byte("model reg 2", u_model.regs[2], old_b);
    axi_write(axil_pkg::REG_STATUS, 32'h3, r);
    check_resp("bresp status write", r, axil_pkg::SLVERR);
    axi_write(axil_pkg::REG_RXDATA, 32'h5, r);
    check_resp("bresp rxdata write", r, axil_pkg::SLVERR);
    axi_write(4'hc, 32'h1, r);
    check_resp("bresp unmapped", r, axil_pkg::SLVERR);
    axi_read(4'hc, w, r);
    check_resp("rresp unmapped", r, axil_pkg::SLVERR);
  endtask

  task automatic test_backpressure();
    axil_pkg::resp_t br;
    axil_pkg::resp_t rr;
    logic [31:0]     rd;
    @(posedge clk);
    bready <= 1'b0;
    rready <= 1'b0;
    axi_write(axil_pkg::REG_STATUS, 32'h0, br);
    check_resp("bresp", br, axil_pkg::SLVERR);
    axi_read(axil_pkg::REG_CMD, rd, rr);
    check_resp("rresp", rr, axil_pkg::OKAY);
    check_word("rdata cmd", rd, 32'(last_sent.raw));
    repeat (5)
    begin
      @(negedge clk);
      check_word("bvalid", 32'(bvalid), 32'h1);
      check_resp("bresp held", bresp, br);
      check_word("rvalid", 32'(rvalid), 32'h1);
      check_word("rdata held", rdata, rd);
      check_resp("rresp held", rresp, rr);
    end
    @(posedge clk);
    araddr  <= axil_pkg::REG_STATUS;
    arvalid <= 1'b1;
    repeat (3)
    begin
      @(negedge clk);
      check_word("arready", 32'(arready), 32'h0);
    end
    @(posedge clk);
    rready <= 1'b1;
    bready <= 1'b1;
    @(negedge clk);
    while (!arready)
      @(negedge clk);
    @(posedge clk);
    arvalid <= 1'b0;
    @(negedge clk);
    while (!rvalid)
      @(negedge clk);
    check_resp("rresp status", rresp, axil_pkg::OKAY);
    check_word("status", rdata, 32'h0);
  endtask

  task automatic test_random();
    spi_frame_pkg::rd_data_t sb [0:7];
    logic [31:0]             v;
    logic [2:0]              base;
    logic [2:0]              addr;
    take_bits(3, v);
    base = v[2:0];
    for (int i = 0; i < 8; i++)
    begin
      addr = base + 3'(i);  // Walks all eight registers once
      take_bits(8, v);
      sb[addr] = v[7:0];
      write_frame(addr, v[7:0]);
      read_frame(addr, sb[addr]);
    end
  endtask

  initial
  begin
    rst_n      = 1'b0;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wstrb      = '0;
    wvalid     = 1'b0;
    bready     = 1'b1;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b1;
    lfsr_state = 32'ha767;
    last_sent  = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    test_reset();
    write_frame(3'd5, 8'hc3);
    read_frame(3'd5, 8'hc3);
    read_frame(3'd6, u_model.regs[6]);
    test_errors();
    test_backpressure();
    test_random();
    $display("sim passed");
    $finish;
  end

endmodule

/* verilog.f */
rtl/spi_frame_pkg.sv
rtl/axil_pkg.sv
rtl/spi_req_if.sv
rtl/spi_shift_if.sv
rtl/axil_spi_regs.sv
rtl/spi_frame_seq.sv
rtl/spi_shifter.sv
rtl/spi_master_top.sv
testbench/spi_device_model.sv
testbench/tb_spi_master.sv
